// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = dcache_tb
FLIST     = dcache_lite.f
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dcache_lite.f
+incdir+src
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/dcache_mem.sv
src/dcache_rd_ctrl.sv
src/dcache_wbuffer.sv
src/dcache_missunit.sv
src/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// File: dv/dcache_tb.sv
// Testbench for the L1 data cache. Drives the load and store ports and
// checks every load against a reference copy of memory.

`include "dcache_cfg.svh"

module dcache_tb
  import dcache_pkg::*;
  import mem_bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // tests take well under 1500 cycles, so this leaves a wide margin
  localparam int MaxCycles = 4000;

  logic      clk = 1'b0;
  logic      rst_n, enable, flush;
  logic      flush_ack, miss, wbuf_empty;
  logic      mem_req_vld, mem_ack, mem_rtrn_vld;
  mem_req_t  mem_req;
  mem_rtrn_t mem_rtrn;
  dc_req_t   req_ports [`DC_NUM_RD+1];
  dc_rsp_t   rsp_ports [`DC_NUM_RD+1];

  dc_word_t ref_mem [16384];
  dc_word_t exp_word [`DC_NUM_RD];
  bit       busy [`DC_NUM_RD];
  int       checks, errors, miss_cnt, cycles;

  always #2 clk = ~clk;

  dcache_top u_dcache_top (
    .clk_i (clk), .rst_n_i (rst_n), .enable_i (enable), .flush_i (flush),
    .flush_ack_o (flush_ack), .miss_o (miss), .wbuffer_empty_o (wbuf_empty),
    .req_ports_i (req_ports), .req_ports_o (rsp_ports),
    .mem_rtrn_vld_i (mem_rtrn_vld), .mem_rtrn_i (mem_rtrn),
    .mem_data_req_o (mem_req_vld), .mem_req_o (mem_req), .mem_data_ack_i (mem_ack)
  );

  mem_model u_mem_model (
    .clk_i (clk), .rst_n_i (rst_n), .req_vld_i (mem_req_vld), .req_i (mem_req),
    .ack_o (mem_ack), .rtrn_vld_o (mem_rtrn_vld), .rtrn_o (mem_rtrn)
  );

  //////////////////////////////////////////////////
  // reference and checking
  //////////////////////////////////////////////////

  function automatic dc_word_t expected_word(input dc_addr_t addr);
    return ref_mem[addr[`DC_ADDR_W-1:2]];
  endfunction

  task automatic check_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // every rvalid against the word captured at grant
  always @(negedge clk) begin
    for (int p = 0; p < `DC_NUM_RD; p++) begin
      if (rst_n && rsp_ports[p].rvalid) begin
        checks++;
        assert (busy[p] && rsp_ports[p].rdata == exp_word[p]) else begin
          $display("CHECK FAILED at %0t ns: port %0d read %h, expected %h",
                   $time, p, rsp_ports[p].rdata, exp_word[p]);
          errors++;
        end
        busy[p] = 1'b0;
      end
    end
    // the store port never answers with data
    if (rst_n) begin
      assert (!rsp_ports[2].rvalid) else begin
        $display("at %0t ns: the store port raised rvalid", $time);
        errors++;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && miss) miss_cnt++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("run stopped after %0d cycles, a handshake never completed", cycles);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // port drivers
  //////////////////////////////////////////////////

  function automatic dc_req_t make_req(input logic we, input dc_addr_t addr,
                                       input dc_word_t data);
    dc_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = data;
    return r;
  endfunction

  // 8 lines at 0x2000 in sets 0 to 7
  function automatic dc_addr_t rand_line_addr();
    return dc_addr_t'(16'h2000 + 16 * ($urandom % 8) + 4 * ($urandom % 4));
  endfunction

  task automatic load_word(input int p, input dc_addr_t addr);
    @(posedge clk);
    req_ports[p] <= make_req(1'b0, addr, '0);
    do @(negedge clk); while (!rsp_ports[p].gnt);
    exp_word[p] = expected_word(addr);
    busy[p] = 1'b1;
    @(posedge clk);
    req_ports[p] <= '0;
    while (busy[p]) @(posedge clk);
  endtask

  // leaves req up so that the next store follows back to back
  task automatic drive_store(input dc_addr_t addr, input dc_word_t data, output int stalls);
    stalls = 0;
    @(posedge clk);
    req_ports[2] <= make_req(1'b1, addr, data);
    @(negedge clk);
    while (!rsp_ports[2].gnt) begin
      stalls++;
      @(negedge clk);
    end
    ref_mem[addr[`DC_ADDR_W-1:2]] = data;
  endtask

  task automatic release_store();
    @(posedge clk);
    req_ports[2] <= '0;
  endtask

  task automatic wait_drain();
    do @(negedge clk); while (!wbuf_empty);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: %s", name, (errors == errs_before) ? "passed" : "failed");
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int base_err;
    int n0;
    int stalls;
    int stall_sum;
    int bad;
    void'($urandom(52));
    rst_n  = 1'b0;
    enable = 1'b1;
    flush  = 1'b0;
    for (int p = 0; p <= `DC_NUM_RD; p++) req_ports[p] = '0;
    for (int i = 0; i < 16384; i++) ref_mem[i] = 32'hC0DE_0000 | i;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    base_err = errors;
    n0 = miss_cnt;
    load_word(0, 16'h1230);
    check_true(miss_cnt == n0 + 1, "first load to a fresh line gave no miss pulse");
    n0 = miss_cnt;
    load_word(1, 16'h1230);
    check_true(miss_cnt == n0, "second load to a cached line pulsed miss");
    report_test("miss then hit", base_err);

    // cached line needs the store to land before the hit reads it
    base_err = errors;
    drive_store(16'h1238, 32'hA5A5_0001, stalls);
    release_store();
    wait_drain();
    load_word(0, 16'h1238);
    drive_store(16'h4560, 32'hA5A5_0002, stalls);
    release_store();
    load_word(1, 16'h4560);
    report_test("store then load", base_err);

    base_err = errors;
    for (int r = 0; r < 10; r++) begin
      repeat (2) begin
        drive_store(rand_line_addr(), $urandom, stalls);
        release_store();
      end
      wait_drain();
      fork
        repeat (10) load_word(0, rand_line_addr());
        repeat (10) load_word(1, rand_line_addr());
      join
    end
    report_test("concurrent load ports", base_err);

    base_err = errors;
    stall_sum = 0;
    for (int i = 0; i < 10; i++) begin
      drive_store(dc_addr_t'(16'h6000 + 4 * ($urandom % 64)), $urandom, stalls);
      stall_sum += stalls;
    end
    release_store();
    check_true(stall_sum > 0, "store gnt never dropped during the burst");
    wait_drain();
    bad = 0;
    for (int i = 0; i < 16384; i++) begin
      if (u_mem_model.mem[i] !== ref_mem[i]) bad++;
    end
    checks++;
    assert (bad == 0) else begin
      $display("CHECK FAILED at %0t ns: %0d memory words differ from the reference",
               $time, bad);
      errors++;
    end
    report_test("store back-pressure", base_err);

    // stores still buffered when flush goes up
    base_err = errors;
    load_word(0, 16'h1230);
    drive_store(16'h1330, 32'hA5A5_0003, stalls);
    drive_store(16'h1334, 32'hA5A5_0004, stalls);
    release_store();
    @(posedge clk);
    flush <= 1'b1;
    do @(negedge clk); while (!flush_ack);
    check_true(wbuf_empty, "flush ack came while stores were still buffered");
    @(posedge clk);
    flush <= 1'b0;
    n0 = miss_cnt;
    load_word(1, 16'h1230);
    check_true(miss_cnt == n0 + 1, "load after flush did not miss");
    report_test("flush", base_err);

    base_err = errors;
    @(posedge clk);
    enable <= 1'b0;
    repeat (2) @(posedge clk);
    n0 = miss_cnt;
    load_word(0, 16'h1230);
    load_word(0, 16'h1230);
    load_word(1, 16'h1334);
    check_true(miss_cnt == n0 + 3, "an uncached load did not go to memory");
    @(posedge clk);
    enable <= 1'b1;
    report_test("uncached loads", base_err);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: dv/mem_model.sv
// Behavioural memory on the cache's bus, 64 KiB held as words.
// Acks a request after a random delay and returns a line or a write ack later.

`include "dcache_cfg.svh"

module mem_model
  import mem_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_vld_i,
  input  mem_req_t  req_i,
  output logic      ack_o,
  output logic      rtrn_vld_o,
  output mem_rtrn_t rtrn_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`DC_WORD_W-1:0] mem [16384];
  logic [1:0]            state_q;
  int unsigned           delay_q;
  mem_req_t              req_q;
  logic [13:0]           base;

  // word index of the first word of the line
  assign base = {req_q.addr[`DC_ADDR_W-1:4], 2'b00};

  // fill pattern carries the whole word index
  initial begin
    for (int i = 0; i < 16384; i++) mem[i] = 32'hC0DE_0000 | i;
  end

  // 0 idle, 1 waiting to ack, 2 waiting to return
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= 2'd0;
      delay_q    <= 0;
      ack_o      <= 1'b0;
      rtrn_vld_o <= 1'b0;
      rtrn_o     <= '0;
    end else begin
      ack_o      <= 1'b0;
      rtrn_vld_o <= 1'b0;
      case (state_q)
        2'd0: if (req_vld_i) begin
          delay_q <= $urandom % 4;
          state_q <= 2'd1;
        end
        2'd1: if (delay_q == 0) begin
          ack_o   <= 1'b1;
          req_q   <= req_i;
          delay_q <= $urandom % 4;
          state_q <= 2'd2;
        end else begin
          delay_q <= delay_q - 1;
        end
        default: if (delay_q == 0) begin
          if (req_q.we) mem[req_q.addr[`DC_ADDR_W-1:2]] <= req_q.wdata;
          rtrn_vld_o  <= 1'b1;
          rtrn_o.we   <= req_q.we;
          rtrn_o.data <= {mem[base+3], mem[base+2], mem[base+1], mem[base]};
          state_q     <= 2'd0;
        end else begin
          delay_q <= delay_q - 1;
        end
      endcase
    end
  end

endmodule

// File: src/dcache_cfg.svh
// Sizing macros for the L1 data cache.
// Include in every package and module that needs a width or a size.

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address and data word
`define DC_ADDR_W 16
`define DC_WORD_W 32

// cache geometry
`define DC_LINE_WORDS 4
`define DC_SETS 16

// load ports, the store port comes on top
`define DC_NUM_RD 2

// store FIFO entries
`define DC_WBUF_DEPTH 4

`endif

// File: src/dcache_mem.sv
// Tag, valid and data arrays of the cache with lookup arbitration.
// Lookups answer one cycle after their grant.

`include "dcache_cfg.svh"

module dcache_mem
  import dcache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dc_rd_port_t rd_port_i [`DC_NUM_RD+1],
  output logic [2:0]  rd_gnt_o,
  output logic        rd_hit_o,
  output dc_word_t    rd_data_o,
  input  logic        cl_we_i,
  input  dc_idx_t     cl_idx_i,
  input  dc_tag_t     cl_tag_i,
  input  dc_line_t    cl_line_i,
  input  logic        wr_req_i,
  input  dc_addr_t    wr_addr_i,
  input  dc_word_t    wr_data_i,
  output logic        wr_ack_o,
  input  logic        inval_all_i
);

  logic [`DC_SETS-1:0] valid_q;
  dc_tag_t             tag_q  [`DC_SETS];
  dc_line_t            data_q [`DC_SETS];

  dc_rd_port_t sel;
  dc_idx_t     wr_idx;
  dc_off_t     wr_off;
  dc_tag_t     wr_tag;
  logic        wr_go;

  // fixed priority with port 0 first
  assign rd_gnt_o[0] = rd_port_i[0].req;
  assign rd_gnt_o[1] = rd_port_i[1].req & ~rd_port_i[0].req;
  assign rd_gnt_o[2] = rd_port_i[2].req & ~rd_port_i[1].req & ~rd_port_i[0].req;

  always_comb begin
    sel = rd_port_i[2];
    if (rd_gnt_o[0]) sel = rd_port_i[0];
    else if (rd_gnt_o[1]) sel = rd_port_i[1];
  end

  assign wr_off = wr_addr_i[2 +: $bits(dc_off_t)];
  assign wr_idx = wr_addr_i[2+$bits(dc_off_t) +: $bits(dc_idx_t)];
  assign wr_tag = wr_addr_i[`DC_ADDR_W-1 -: $bits(dc_tag_t)];
  // refills take the array and word writes wait
  assign wr_go  = wr_req_i & ~cl_we_i & ~wr_ack_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= '0;
      rd_hit_o <= 1'b0;
      wr_ack_o <= 1'b0;
    end else begin
      rd_hit_o <= |rd_gnt_o & valid_q[sel.idx] & (tag_q[sel.idx] == sel.tag);
      wr_ack_o <= wr_go;
      if (inval_all_i) valid_q <= '0;
      else if (cl_we_i) valid_q[cl_idx_i] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////
  // arrays and read data
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    rd_data_o <= data_q[sel.idx][sel.off*`DC_WORD_W +: `DC_WORD_W];
    if (cl_we_i) begin
      tag_q[cl_idx_i]  <= cl_tag_i;
      data_q[cl_idx_i] <= cl_line_i;
    end else if (wr_go && valid_q[wr_idx] && tag_q[wr_idx] == wr_tag) begin
      // store hit patches the one word
      data_q[wr_idx][wr_off*`DC_WORD_W +: `DC_WORD_W] <= wr_data_i;
    end
  end

  // a word write keeps its address and data until acked
  a_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_req_i && !wr_ack_o |=> wr_req_i && $stable(wr_addr_i) && $stable(wr_data_i));

endmodule

// File: src/dcache_missunit.sv
// Miss handling unit: owns the memory bus, one transaction at a time.
// Refills lines, routes returns and serves flush.

`include "dcache_cfg.svh"

module dcache_missunit
  import dcache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       flush_i,
  output logic       flush_ack_o,
  output logic       miss_o,
  output logic       cache_en_o,
  input  logic       wbuf_empty_i,
  input  miss_req_t  miss_i [`DC_NUM_RD+1],
  output logic [2:0] miss_ack_o,
  output logic [2:0] miss_done_o,
  output dc_line_t   miss_line_o,
  output logic       cl_we_o,
  output dc_idx_t    cl_idx_o,
  output dc_tag_t    cl_tag_o,
  output dc_line_t   cl_line_o,
  output logic       inval_all_o,
  output logic       mem_data_req_o,
  output mem_req_t   mem_req_o,
  input  logic       mem_data_ack_i,
  input  logic       mem_rtrn_vld_i,
  input  mem_rtrn_t  mem_rtrn_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_e;

  state_e     state_q;
  miss_req_t  req_q;
  logic [1:0] owner_q, rr_q, pick;
  logic [2:0] elig;
  logic       found;

  // loads wait for the store FIFO so that they see every older store
  always_comb begin
    for (int i = 0; i < `DC_NUM_RD; i++) elig[i] = miss_i[i].req & wbuf_empty_i;
    elig[2] = miss_i[2].req;
  end

  // round robin starting after the last owner
  always_comb begin
    logic [1:0] p;
    pick  = '0;
    found = 1'b0;
    for (int i = 1; i <= 3; i++) begin
      p = 2'((int'(rr_q) + i) % 3);
      if (!found && elig[p]) begin
        pick  = p;
        found = 1'b1;
      end
    end
  end

  assign flush_ack_o = (state_q == IDLE) & flush_i & wbuf_empty_i;
  assign inval_all_o = flush_ack_o;

  always_comb begin
    miss_ack_o = '0;
    if (state_q == IDLE && !flush_ack_o && found) miss_ack_o[pick] = 1'b1;
  end
  assign miss_o = |miss_ack_o[`DC_NUM_RD-1:0];

  assign mem_data_req_o  = state_q == REQ;
  assign mem_req_o.we    = req_q.we;
  // reads fetch the whole line
  assign mem_req_o.addr  = req_q.we ? req_q.addr : {req_q.addr[`DC_ADDR_W-1:4], 4'b0};
  assign mem_req_o.wdata = req_q.wdata;

  ////////////////////////////////////////////////
  // returns
  ////////////////////////////////////////////////

  always_comb begin
    miss_done_o = '0;
    if (state_q == WAIT && mem_rtrn_vld_i) miss_done_o[owner_q] = 1'b1;
  end
  assign miss_line_o = mem_rtrn_i.data;
  assign cl_line_o   = mem_rtrn_i.data;
  assign cl_idx_o    = req_q.addr[2+$bits(dc_off_t) +: $bits(dc_idx_t)];
  assign cl_tag_o    = req_q.addr[`DC_ADDR_W-1 -: $bits(dc_tag_t)];
  // a store that arrived during the read may be newer than the line
  assign cl_we_o = (state_q == WAIT) & mem_rtrn_vld_i & ~mem_rtrn_i.we & ~req_q.nc
                   & wbuf_empty_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      owner_q    <= '0;
      rr_q       <= 2'd2;
      cache_en_o <= 1'b0;
    end else begin
      cache_en_o <= enable_i;
      case (state_q)
        IDLE: if (|miss_ack_o) begin
          owner_q <= pick;
          rr_q    <= pick;
          state_q <= REQ;
        end
        REQ:  if (mem_data_ack_i) state_q <= WAIT;
        WAIT: if (mem_rtrn_vld_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (|miss_ack_o) req_q <= miss_i[pick];
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_data_req_o && !mem_data_ack_i |=> mem_data_req_o && $stable(mem_req_o));

endmodule

// File: src/dcache_pkg.sv
// Core-side request and response types of the data cache, plus the
// fields that an address splits into.

`include "dcache_cfg.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0] dc_addr_t;
  typedef logic [`DC_WORD_W-1:0] dc_word_t;
  typedef logic [$clog2(`DC_SETS)-1:0] dc_idx_t;
  typedef logic [$clog2(`DC_LINE_WORDS)-1:0] dc_off_t;
  // what is left above index, offset and byte bits
  typedef logic [`DC_ADDR_W-$clog2(`DC_SETS)-$clog2(`DC_LINE_WORDS)-3:0] dc_tag_t;

  typedef struct packed {
    logic     req;
    logic     we;
    dc_addr_t addr;
    dc_word_t wdata;
  } dc_req_t;

  typedef struct packed {
    logic     gnt;
    logic     rvalid;
    dc_word_t rdata;
  } dc_rsp_t;

  // lookup into the arrays
  typedef struct packed {
    logic    req;
    dc_idx_t idx;
    dc_off_t off;
    dc_tag_t tag;
  } dc_rd_port_t;

  typedef struct packed {
    logic     req;
    logic     we;
    logic     nc;
    dc_addr_t addr;
    dc_word_t wdata;
  } miss_req_t;

endpackage

// File: src/dcache_rd_ctrl.sv
// Controller of one load port: lookup, miss request and response.
// One instance per load port under the cache top level.

`include "dcache_cfg.svh"

module dcache_rd_ctrl
  import dcache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cache_en_i,
  input  dc_req_t     req_i,
  output dc_rsp_t     rsp_o,
  output dc_rd_port_t rd_port_o,
  input  logic        rd_gnt_i,
  input  logic        rd_hit_i,
  input  dc_word_t    rd_data_i,
  output miss_req_t   miss_o,
  input  logic        miss_ack_i,
  input  logic        miss_done_i,
  input  dc_line_t    miss_line_i
);

  typedef enum logic [1:0] {IDLE, LOOKUP, MISS_WAIT, RESPOND} state_e;

  state_e   state_q;
  dc_addr_t addr_q;
  logic     nc_q;
  logic     acked_q;
  dc_word_t word_q;
  dc_off_t  off_q;

  assign off_q = addr_q[2 +: $bits(dc_off_t)];

  assign rd_port_o.req = (state_q == IDLE) & req_i.req & cache_en_i;
  assign rd_port_o.off = req_i.addr[2 +: $bits(dc_off_t)];
  assign rd_port_o.idx = req_i.addr[2+$bits(dc_off_t) +: $bits(dc_idx_t)];
  assign rd_port_o.tag = req_i.addr[`DC_ADDR_W-1 -: $bits(dc_tag_t)];

  // uncached loads skip the lookup and go straight to memory
  assign rsp_o.gnt    = (state_q == IDLE) & req_i.req & (rd_gnt_i | ~cache_en_i);
  assign rsp_o.rvalid = (state_q == LOOKUP & rd_hit_i) | (state_q == RESPOND);
  assign rsp_o.rdata  = (state_q == RESPOND) ? word_q : rd_data_i;

  assign miss_o.req   = (state_q == MISS_WAIT) & ~acked_q;
  assign miss_o.we    = 1'b0;
  assign miss_o.nc    = nc_q;
  assign miss_o.addr  = addr_q;
  assign miss_o.wdata = '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      acked_q <= 1'b0;
      nc_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (rsp_o.gnt) begin
          nc_q    <= ~cache_en_i;
          acked_q <= 1'b0;
          state_q <= cache_en_i ? LOOKUP : MISS_WAIT;
        end
        LOOKUP: state_q <= rd_hit_i ? IDLE : MISS_WAIT;
        MISS_WAIT: begin
          if (miss_ack_i) acked_q <= 1'b1;
          if (miss_done_i) state_q <= RESPOND;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_o.gnt) addr_q <= req_i.addr;
    if (miss_done_i) word_q <= miss_line_i[off_q*`DC_WORD_W +: `DC_WORD_W];
  end

  a_rvalid_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.rvalid |=> !rsp_o.rvalid);

endmodule

// File: src/dcache_top.sv
// Top level of the write-through L1 data cache.
// Ports 0 and 1 take loads, port 2 takes stores.

`include "dcache_cfg.svh"

module dcache_top
  import dcache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      enable_i,
  input  logic      flush_i,
  output logic      flush_ack_o,
  output logic      miss_o,
  output logic      wbuffer_empty_o,
  input  dc_req_t   req_ports_i [`DC_NUM_RD+1],
  output dc_rsp_t   req_ports_o [`DC_NUM_RD+1],
  input  logic      mem_rtrn_vld_i,
  input  mem_rtrn_t mem_rtrn_i,
  output logic      mem_data_req_o,
  output mem_req_t  mem_req_o,
  input  logic      mem_data_ack_i
);

  logic        cache_en, rd_hit, cl_we, wr_req, wr_ack, inval_all;
  logic [2:0]  rd_gnt, miss_ack, miss_done;
  dc_rd_port_t rd_port [`DC_NUM_RD+1];
  miss_req_t   miss_req [`DC_NUM_RD+1];
  dc_word_t    rd_data, wr_data;
  dc_addr_t    wr_addr;
  dc_idx_t     cl_idx;
  dc_tag_t     cl_tag;
  dc_line_t    cl_line, miss_line;

  dcache_missunit u_missunit (
    .clk_i, .rst_n_i, .enable_i, .flush_i, .flush_ack_o, .miss_o,
    .cache_en_o (cache_en), .wbuf_empty_i (wbuffer_empty_o),
    .miss_i (miss_req), .miss_ack_o (miss_ack), .miss_done_o (miss_done),
    .miss_line_o (miss_line), .cl_we_o (cl_we), .cl_idx_o (cl_idx), .cl_tag_o (cl_tag),
    .cl_line_o (cl_line), .inval_all_o (inval_all), .mem_data_req_o, .mem_req_o,
    .mem_data_ack_i, .mem_rtrn_vld_i, .mem_rtrn_i
  );

  // load ports
  for (genvar k = 0; k < `DC_NUM_RD; k++) begin : gen_rd
    dcache_rd_ctrl u_rd_ctrl (
      .clk_i, .rst_n_i, .cache_en_i (cache_en),
      .req_i (req_ports_i[k]), .rsp_o (req_ports_o[k]),
      .rd_port_o (rd_port[k]), .rd_gnt_i (rd_gnt[k]), .rd_hit_i (rd_hit),
      .rd_data_i (rd_data), .miss_o (miss_req[k]), .miss_ack_i (miss_ack[k]),
      .miss_done_i (miss_done[k]), .miss_line_i (miss_line)
    );
  end

  dcache_wbuffer u_wbuffer (
    .clk_i, .rst_n_i, .req_i (req_ports_i[2]), .rsp_o (req_ports_o[2]),
    .rd_port_o (rd_port[2]), .rd_gnt_i (rd_gnt[2]), .rd_hit_i (rd_hit),
    .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_data_o (wr_data), .wr_ack_i (wr_ack),
    .miss_o (miss_req[2]), .miss_ack_i (miss_ack[2]), .miss_done_i (miss_done[2]),
    .empty_o (wbuffer_empty_o)
  );

  dcache_mem u_mem (
    .clk_i, .rst_n_i, .rd_port_i (rd_port), .rd_gnt_o (rd_gnt), .rd_hit_o (rd_hit),
    .rd_data_o (rd_data), .cl_we_i (cl_we), .cl_idx_i (cl_idx), .cl_tag_i (cl_tag),
    .cl_line_i (cl_line), .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
    .wr_ack_o (wr_ack), .inval_all_i (inval_all)
  );

endmodule

// File: src/dcache_wbuffer.sv
// Store FIFO whose entries patch the cache on a hit and then drain to memory.
// An entry leaves the FIFO once its memory write is acknowledged.

`include "dcache_cfg.svh"

module dcache_wbuffer
  import dcache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dc_req_t     req_i,
  output dc_rsp_t     rsp_o,
  output dc_rd_port_t rd_port_o,
  input  logic        rd_gnt_i,
  input  logic        rd_hit_i,
  output logic        wr_req_o,
  output dc_addr_t    wr_addr_o,
  output dc_word_t    wr_data_o,
  input  logic        wr_ack_i,
  output miss_req_t   miss_o,
  input  logic        miss_ack_i,
  input  logic        miss_done_i,
  output logic        empty_o
);

  localparam int PtrW = $clog2(`DC_WBUF_DEPTH);

  typedef enum logic [1:0] {LOOK, CHECK, WRITE, DRAIN} head_e;

  head_e           head_q;
  dc_addr_t        addr_q [`DC_WBUF_DEPTH];
  dc_word_t        data_q [`DC_WBUF_DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   cnt_q;
  logic            full, push, pop, acked_q;

  assign full    = cnt_q == (PtrW+1)'(`DC_WBUF_DEPTH);
  assign empty_o = cnt_q == '0;
  assign push    = req_i.req & ~full;
  assign pop     = (head_q == DRAIN) & miss_done_i;

  assign rsp_o.gnt    = push;
  assign rsp_o.rvalid = 1'b0;
  assign rsp_o.rdata  = '0;

  assign rd_port_o.req = (head_q == LOOK) & ~empty_o;
  assign rd_port_o.off = addr_q[rd_ptr_q][2 +: $bits(dc_off_t)];
  assign rd_port_o.idx = addr_q[rd_ptr_q][2+$bits(dc_off_t) +: $bits(dc_idx_t)];
  assign rd_port_o.tag = addr_q[rd_ptr_q][`DC_ADDR_W-1 -: $bits(dc_tag_t)];

  assign wr_req_o  = head_q == WRITE;
  assign wr_addr_o = addr_q[rd_ptr_q];
  assign wr_data_o = data_q[rd_ptr_q];

  assign miss_o.req   = (head_q == DRAIN) & ~acked_q;
  assign miss_o.we    = 1'b1;
  assign miss_o.nc    = 1'b0;
  assign miss_o.addr  = addr_q[rd_ptr_q];
  assign miss_o.wdata = data_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q   <= LOOK;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      acked_q  <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + push - pop;
      case (head_q)
        LOOK:  if (rd_gnt_i) head_q <= CHECK;
        CHECK: head_q <= rd_hit_i ? WRITE : DRAIN;
        WRITE: if (wr_ack_i) head_q <= DRAIN;
        default: begin
          if (miss_ack_i) acked_q <= 1'b1;
          if (miss_done_i) begin
            acked_q <= 1'b0;
            head_q  <= LOOK;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_q[wr_ptr_q] <= req_i.addr;
      data_q[wr_ptr_q] <= req_i.wdata;
    end
  end

  // occupancy stays within the depth and agrees with the pointers
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= (PtrW+1)'(`DC_WBUF_DEPTH) &&
    PtrW'(wr_ptr_q - rd_ptr_q) == cnt_q[PtrW-1:0]);

endmodule

// File: src/mem_bus_pkg.sv
// Types of the memory bus behind the cache.
// Requests carry one word, returns carry a whole line.

`include "dcache_cfg.svh"

package mem_bus_pkg;

  typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0] dc_line_t;

  typedef struct packed {
    logic                  we;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_WORD_W-1:0] wdata;
  } mem_req_t;

  // a write return is only an acknowledgement
  typedef struct packed {
    logic     we;
    dc_line_t data;
  } mem_rtrn_t;

endpackage
